// ==== source/iigs_pkg.sv ====
package iigs_pkg;

	typedef logic [7:0]  bank_t;
	typedef logic [15:0] addr16_t;
	typedef logic [7:0]  byte_t;

	// C0xx offsets handled by the glue
	typedef enum logic [7:0] {
		OFF_CLR80STORE   = 8'h00,
		OFF_SET80STORE   = 8'h01,
		OFF_RDMAINRAM    = 8'h02,
		OFF_RDCARDRAM    = 8'h03,
		OFF_WRMAINRAM    = 8'h04,
		OFF_WRCARDRAM    = 8'h05,
		OFF_SETSLOTCXROM = 8'h06,
		OFF_SETINTCXROM  = 8'h07,
		OFF_SETSTDZP     = 8'h08,
		OFF_SETALTZP     = 8'h09,
		OFF_SETINTC3ROM  = 8'h0A,
		OFF_SETSLOTC3ROM = 8'h0B,
		OFF_CLR80VID     = 8'h0C,
		OFF_SET80VID     = 8'h0D,
		OFF_CLRALTCHAR   = 8'h0E,
		OFF_SETALTCHAR   = 8'h0F,
		OFF_RDLCBNK2     = 8'h11,  // status reads, flag in bit 7
		OFF_RDLCRAM      = 8'h12,
		OFF_RDRAMRD      = 8'h13,
		OFF_RDRAMWRT     = 8'h14,
		OFF_RDCXROM      = 8'h15,
		OFF_RDALTZP      = 8'h16,
		OFF_RDC3ROM      = 8'h17,
		OFF_RD80STORE    = 8'h18,
		OFF_RDVBLBAR     = 8'h19,
		OFF_RDTEXT       = 8'h1A,
		OFF_RDMIXED      = 8'h1B,
		OFF_RDPAGE2      = 8'h1C,
		OFF_RDHIRES      = 8'h1D,
		OFF_RDALTCHAR    = 8'h1E,
		OFF_RD80VID      = 8'h1F,
		OFF_TEXTCOLOR    = 8'h22,
		OFF_VGCINT       = 8'h23,
		OFF_NEWVIDEO     = 8'h29,
		OFF_SLTROMSEL    = 8'h2D,
		OFF_SCANINT      = 8'h32,  // vgc interrupt clear
		OFF_CLOCKCTL     = 8'h34,  // border color in low nibble
		OFF_SHADOW       = 8'h35,
		OFF_INTEN        = 8'h41,
		OFF_CLRVBLINT    = 8'h47,
		OFF_TXTCLR       = 8'h50,
		OFF_TXTSET       = 8'h51,
		OFF_MIXCLR       = 8'h52,
		OFF_MIXSET       = 8'h53,
		OFF_TXTPAGE1     = 8'h54,
		OFF_TXTPAGE2     = 8'h55,
		OFF_LORES        = 8'h56,
		OFF_HIRES        = 8'h57,
		OFF_STATEREG     = 8'h68,
		OFF_LCBASE       = 8'h80   // language card window 80-8F
	} io_off_e;

	localparam bank_t BANK_MAIN      = 8'h00;
	localparam bank_t BANK_AUX       = 8'h01;
	localparam bank_t BANK_MEGA_MAIN = 8'hE0;
	localparam bank_t BANK_MEGA_AUX  = 8'hE1;
	localparam byte_t IO_PAGE        = 8'hC0;

endpackage

// ==== source/softswitch_regs.sv ====
`timescale 1ns/10ps

module softswitch_regs import iigs_pkg::*; #(
	parameter byte_t SHADOW_INIT    = 8'h08,
	parameter byte_t TEXTCOLOR_INIT = 8'hF2,
	parameter byte_t NEWVIDEO_INIT  = 8'h41
) (
	input  logic       clk_sys,
	input  logic       cpu_vda,
	input  logic       bus_strobe,
	input  logic       cpu_we,
	input  bank_t      cpu_bank,
	input  addr16_t    cpu_addr,
	input  byte_t      cpu_wdata,
	input  logic       vblank,
	input  logic       rdrom,
	input  logic       lcram2,
	input  byte_t      vgcint,
	input  byte_t      inten,
	output byte_t      rd_data,
	output logic       rd_valid,
	output logic       store80,
	output logic       ramrd,
	output logic       ramwrt,
	output logic       altzp,
	output logic       intcxrom,
	output logic       slotc3rom,
	output logic       eightycol,
	output logic       altcharset,
	output logic       page2,
	output logic       textg,
	output logic       mixg,
	output logic       hires_mode,
	output byte_t      shadow,
	output byte_t      textcolor,
	output logic [3:0] bordercolor,
	output byte_t      newvideo,
	output logic       lc_access,
	output logic [3:0] lc_off,
	output logic       lc_read,
	output logic       state_load,
	output byte_t      state_data,
	output logic       wr_vgc_en,
	output logic       wr_vgc_clr,
	output logic       wr_inten,
	output logic       clr_intflag,
	output byte_t      wdata
);

	io_off_e off;
	logic    io_bank;
	logic    io_hit;
	logic    io_wr;
	byte_t   sltromsel;
	byte_t   statereg;
	byte_t   rd_mux;

	assign off = io_off_e'(cpu_addr[7:0]);
	assign io_bank = (cpu_bank == BANK_MAIN) | (cpu_bank == BANK_AUX) |
		(cpu_bank == BANK_MEGA_MAIN) | (cpu_bank == BANK_MEGA_AUX);
	// C0 page is only IO while shadowing of IO is on (bit 6 clear)
	assign io_hit = bus_strobe & io_bank & ~shadow[6] & (cpu_addr[15:8] == IO_PAGE);
	assign io_wr = io_hit & cpu_we;

	assign statereg = {altzp, page2, ramrd, ramwrt, rdrom, lcram2, 1'b0, intcxrom};

	// pulses to the language card and irq block
	assign lc_access   = io_hit & ((cpu_addr[7:0] & 8'hF0) == OFF_LCBASE);
	assign lc_off      = cpu_addr[3:0];
	assign lc_read     = ~cpu_we;
	assign state_load  = io_wr & (off == OFF_STATEREG);
	assign state_data  = cpu_wdata;
	assign wr_vgc_en   = io_wr & (off == OFF_VGCINT);
	assign wr_vgc_clr  = io_wr & (off == OFF_SCANINT);
	assign wr_inten    = io_wr & (off == OFF_INTEN);
	assign clr_intflag = io_wr & (off == OFF_CLRVBLINT);
	assign wdata       = cpu_wdata;

	always_ff @(posedge clk_sys or posedge cpu_vda) begin
		if (cpu_vda) begin
			{store80, ramrd, ramwrt, altzp} <= 4'b0;
			{intcxrom, slotc3rom, eightycol, altcharset} <= 4'b0;
			{page2, textg, mixg, hires_mode} <= 4'b0;
			shadow <= SHADOW_INIT;
			textcolor <= TEXTCOLOR_INIT;
			newvideo <= NEWVIDEO_INIT;
			bordercolor <= 4'h0;
			sltromsel <= 8'h00;
		end else if (io_hit) begin
			// even offset clears, odd offset sets
			case (off)
				OFF_CLR80STORE, OFF_SET80STORE: if (cpu_we) store80 <= cpu_addr[0];
				OFF_RDMAINRAM, OFF_RDCARDRAM: ramrd <= cpu_addr[0];  // reads switch too
				OFF_WRMAINRAM, OFF_WRCARDRAM: ramwrt <= cpu_addr[0];
				OFF_SETSLOTCXROM, OFF_SETINTCXROM: if (cpu_we) intcxrom <= cpu_addr[0];
				OFF_SETSTDZP, OFF_SETALTZP: if (cpu_we) altzp <= cpu_addr[0];
				OFF_SETINTC3ROM, OFF_SETSLOTC3ROM: if (cpu_we) slotc3rom <= cpu_addr[0];
				OFF_CLR80VID, OFF_SET80VID: if (cpu_we) eightycol <= cpu_addr[0];
				OFF_CLRALTCHAR, OFF_SETALTCHAR: if (cpu_we) altcharset <= cpu_addr[0];
				OFF_TXTCLR, OFF_TXTSET: textg <= cpu_addr[0];
				OFF_MIXCLR, OFF_MIXSET: mixg <= cpu_addr[0];
				OFF_TXTPAGE1, OFF_TXTPAGE2: page2 <= cpu_addr[0];
				OFF_LORES, OFF_HIRES: hires_mode <= cpu_addr[0];
				OFF_TEXTCOLOR: if (cpu_we) textcolor <= cpu_wdata;
				OFF_NEWVIDEO: if (cpu_we) newvideo <= cpu_wdata;
				OFF_SLTROMSEL: if (cpu_we) sltromsel <= cpu_wdata;
				OFF_CLOCKCTL: if (cpu_we) bordercolor <= cpu_wdata[3:0];
				OFF_SHADOW: if (cpu_we) shadow <= cpu_wdata;
				OFF_STATEREG: begin
					// rdrom and lcram2 live in the language card
					if (cpu_we) begin
						{altzp, page2, ramrd, ramwrt} <= cpu_wdata[7:4];
						intcxrom <= cpu_wdata[0];
					end
				end
				default: ;
			endcase
		end
	end

	always_comb begin
		rd_mux = 8'h00;
		case (off)
			OFF_RDLCBNK2:  rd_mux = {lcram2, 7'b0};
			OFF_RDLCRAM:   rd_mux = {rdrom, 7'b0};
			OFF_RDRAMRD:   rd_mux = {ramrd, 7'b0};
			OFF_RDRAMWRT:  rd_mux = {ramwrt, 7'b0};
			OFF_RDCXROM:   rd_mux = {intcxrom, 7'b0};
			OFF_RDALTZP:   rd_mux = {altzp, 7'b0};
			OFF_RDC3ROM:   rd_mux = {slotc3rom, 7'b0};
			OFF_RD80STORE: rd_mux = {store80, 7'b0};
			OFF_RDVBLBAR:  rd_mux = {~vblank, 7'b0};  // active outside blanking
			OFF_RDTEXT:    rd_mux = {textg, 7'b0};
			OFF_RDMIXED:   rd_mux = {mixg, 7'b0};
			OFF_RDPAGE2:   rd_mux = {page2, 7'b0};
			OFF_RDHIRES:   rd_mux = {~hires_mode, 7'b0};
			OFF_RDALTCHAR: rd_mux = {altcharset, 7'b0};
			OFF_RD80VID:   rd_mux = {eightycol, 7'b0};
			OFF_TEXTCOLOR: rd_mux = textcolor;
			OFF_VGCINT:    rd_mux = vgcint;
			OFF_NEWVIDEO:  rd_mux = newvideo;
			OFF_SLTROMSEL: rd_mux = sltromsel;
			OFF_CLOCKCTL:  rd_mux = {4'h0, bordercolor};
			OFF_SHADOW:    rd_mux = shadow;
			OFF_INTEN:     rd_mux = inten;
			OFF_STATEREG:  rd_mux = statereg;
			default:       rd_mux = 8'h00;
		endcase
	end

	// one cycle read latency
	always_ff @(posedge clk_sys or posedge cpu_vda) begin
		if (cpu_vda)
			rd_valid <= 1'b0;
		else
			rd_valid <= io_hit & ~cpu_we;
	end

	always_ff @(posedge clk_sys) begin
		if (io_hit && !cpu_we)
			rd_data <= rd_mux;  // holds between reads
	end

endmodule

// ==== source/lang_card.sv ====
`timescale 1ns/10ps

// language card soft switches C080-C08F
//   bit 3 of the offset picks bank 1 (set) or bank 2 (clear)
//   bits 1:0 pick the read source, 00/11 RAM and 01/10 ROM
//   odd offsets arm write enable, it takes two reads in a row
module lang_card import iigs_pkg::*; (
	input  logic       clk_sys,
	input  logic       cpu_vda,
	input  logic       lc_access,
	input  logic [3:0] lc_off,
	input  logic       lc_read,
	input  logic       state_load,
	input  byte_t      state_data,
	output logic       rdrom,
	output logic       lcram2,
	output logic       lc_we
);

	logic lc_pre;     // first odd read seen
	logic odd_read;
	logic rom_sel;

	assign odd_read = lc_read & lc_off[0];
	assign rom_sel = lc_off[1] ^ lc_off[0];

	always_ff @(posedge clk_sys or posedge cpu_vda) begin
		if (cpu_vda) begin
			rdrom  <= 1'b1;  // boot from rom
			lcram2 <= 1'b0;
			lc_we  <= 1'b0;
			lc_pre <= 1'b0;
		end else if (lc_access) begin
			lcram2 <= ~lc_off[3];
			rdrom  <= rom_sel;

			if (odd_read) begin
				// second successive odd read enables writes
				lc_we  <= lc_pre;
				lc_pre <= 1'b1;
			end else begin
				// even offset or any write disarms
				lc_we  <= 1'b0;
				lc_pre <= 1'b0;
			end
		end else if (state_load) begin
			rdrom  <= state_data[3];  // STATEREG bit 3
			lcram2 <= state_data[2];  // STATEREG bit 2
		end
	end

endmodule

// ==== source/aux_map.sv ====
`timescale 1ns/10ps

module aux_map import iigs_pkg::*; (
	input  bank_t   cpu_bank,
	input  addr16_t cpu_addr,
	input  logic    cpu_we,
	input  logic    store80,
	input  logic    page2,
	input  logic    hires_mode,
	input  logic    ramrd,
	input  logic    ramwrt,
	input  logic    altzp,
	input  logic    rdrom,
	input  logic    lcram2,
	input  byte_t   shadow,
	output bank_t   mem_bank,
	output addr16_t mem_addr
);

	logic main_bank;   // 00 or E0, the only banks with an aux twin
	logic low_bank;    // 00 or 01
	logic mega_bank;   // E0 or E1
	logic zp_area;
	logic text_area;
	logic hgr_area;
	logic ram_sel;
	logic aux;
	logic lc_window;
	logic lc_move;

	assign main_bank = (cpu_bank == BANK_MAIN) | (cpu_bank == BANK_MEGA_MAIN);
	assign low_bank  = (cpu_bank == BANK_MAIN) | (cpu_bank == BANK_AUX);
	assign mega_bank = (cpu_bank == BANK_MEGA_MAIN) | (cpu_bank == BANK_MEGA_AUX);

	assign zp_area   = (cpu_addr[15:9] == 7'b0000000) | (cpu_addr[15:14] == 2'b11);
	assign text_area = cpu_addr[15:10] == 6'b000001;  // pages 04-07
	assign hgr_area  = cpu_addr[15:13] == 3'b001;     // pages 20-3F

	assign ram_sel = cpu_we ? ramwrt : ramrd;

	always_comb begin
		aux = 1'b0;
		if (main_bank) begin
			if (zp_area)
				aux = altzp;
			else if (text_area && store80)
				aux = page2;
			else if (hgr_area && store80 && hires_mode)
				aux = page2;
			else
				aux = ram_sel;
		end
	end

	// bank 2 of the language card sits at C000-CFFF in ram
	assign lc_window = (cpu_addr[15:12] == 4'hD) & lcram2 & ~rdrom;
	assign lc_move = lc_window & (mega_bank | (low_bank & ~shadow[6]));

	assign mem_addr = lc_move ? cpu_addr - 16'h1000 : cpu_addr;
	assign mem_bank = aux ? cpu_bank + 8'h01 : cpu_bank;  // 00->01, E0->E1

endmodule

// ==== source/irq_ctrl.sv ====
`timescale 1ns/10ps

module irq_ctrl import iigs_pkg::*; (
	input  logic  clk_sys,
	input  logic  cpu_vda,
	input  logic  scanline_irq,
	input  logic  onesecond_irq,
	input  logic  vbl_irq,
	input  logic  qtrsecond_irq,
	input  logic  wr_vgc_en,
	input  logic  wr_vgc_clr,
	input  logic  wr_inten,
	input  logic  clr_intflag,
	input  byte_t wdata,
	output byte_t vgcint,
	output byte_t inten,
	output logic  irq
);

	logic [4:3] intflag;  // quarter second and vbl status
	logic       vgc_any_left;

	// bit 7 survives only while a status bit stays set
	assign vgc_any_left = (vgcint[5] & wdata[5]) | (vgcint[6] & wdata[6]);

	always_ff @(posedge clk_sys or posedge cpu_vda) begin
		if (cpu_vda) begin
			vgcint  <= 8'h00;
			inten   <= 8'h00;
			intflag <= 2'b00;
		end else begin
			if (wr_vgc_en)
				vgcint[2:1] <= wdata[2:1];  // only the enables are writable
			if (wr_vgc_clr) begin
				if (!wdata[6]) vgcint[6] <= 1'b0;
				if (!wdata[5]) vgcint[5] <= 1'b0;
				if (!vgc_any_left) vgcint[7] <= 1'b0;
			end
			if (wr_inten)
				inten[4:0] <= wdata[4:0];
			if (clr_intflag)
				intflag <= 2'b00;

			// events win over a clear on the same cycle
			if (scanline_irq) begin
				vgcint[5] <= 1'b1;  // status even when disabled
				if (vgcint[1])
					vgcint[7] <= 1'b1;
			end
			if (onesecond_irq && vgcint[2]) begin
				vgcint[6] <= 1'b1;
				vgcint[7] <= 1'b1;
			end
			if (vbl_irq && inten[3])
				intflag[3] <= 1'b1;
			if (qtrsecond_irq && inten[4])
				intflag[4] <= 1'b1;
		end
	end

	assign irq = (vgcint[6] & vgcint[2]) | (vgcint[5] & vgcint[1]) |
		(intflag[3] & inten[3]) | (intflag[4] & inten[4]);

endmodule

// ==== source/iigs_glue.sv ====
`timescale 1ns/10ps

module iigs_glue import iigs_pkg::*; #(
	parameter byte_t SHADOW_INIT    = 8'h08,
	parameter byte_t TEXTCOLOR_INIT = 8'hF2,
	parameter byte_t NEWVIDEO_INIT  = 8'h41
) (
	input  logic       clk_sys,
	input  logic       cpu_vda,        // reset
	input  logic       bus_strobe,
	input  logic       cpu_we,
	input  bank_t      cpu_bank,
	input  addr16_t    cpu_addr,
	input  byte_t      cpu_wdata,
	input  logic       scanline_irq,
	input  logic       vbl_irq,
	input  logic       onesecond_irq,
	input  logic       qtrsecond_irq,
	input  logic       vblank,
	output byte_t      rd_data,
	output logic       rd_valid,
	output bank_t      mem_bank,
	output addr16_t    mem_addr,
	output logic       irq,
	output byte_t      shadow,
	output byte_t      textcolor,
	output logic [3:0] bordercolor,
	output byte_t      newvideo,
	output logic       page2,
	output logic       textg,
	output logic       mixg,
	output logic       hires_mode,
	output logic       rdrom,
	output logic       lcram2,
	output logic       lc_we
);

	logic       store80, ramrd, ramwrt, altzp;
	logic       lc_access, lc_read, state_load;
	logic [3:0] lc_off;
	byte_t      state_data, wdata, vgcint, inten;
	logic       wr_vgc_en, wr_vgc_clr, wr_inten, clr_intflag;

	softswitch_regs #(
		.SHADOW_INIT   (SHADOW_INIT),
		.TEXTCOLOR_INIT(TEXTCOLOR_INIT),
		.NEWVIDEO_INIT (NEWVIDEO_INIT)
	) regs_i (
		.clk_sys, .cpu_vda, .bus_strobe, .cpu_we, .cpu_bank, .cpu_addr, .cpu_wdata,
		.vblank, .rdrom, .lcram2, .vgcint, .inten, .rd_data, .rd_valid,
		.store80, .ramrd, .ramwrt, .altzp,
		.intcxrom(), .slotc3rom(), .eightycol(), .altcharset(),  // status reads only
		.page2, .textg, .mixg, .hires_mode, .shadow, .textcolor, .bordercolor, .newvideo,
		.lc_access, .lc_off, .lc_read, .state_load, .state_data,
		.wr_vgc_en, .wr_vgc_clr, .wr_inten, .clr_intflag, .wdata
	);

	lang_card lc_i (
		.clk_sys, .cpu_vda, .lc_access, .lc_off, .lc_read, .state_load, .state_data,
		.rdrom, .lcram2, .lc_we
	);

	aux_map map_i (
		.cpu_bank, .cpu_addr, .cpu_we, .store80, .page2, .hires_mode, .ramrd, .ramwrt,
		.altzp, .rdrom, .lcram2, .shadow, .mem_bank, .mem_addr
	);

	irq_ctrl irq_i (
		.clk_sys, .cpu_vda, .scanline_irq, .onesecond_irq, .vbl_irq, .qtrsecond_irq,
		.wr_vgc_en, .wr_vgc_clr, .wr_inten, .clr_intflag, .wdata, .vgcint, .inten, .irq
	);

endmodule

// ==== bench/glue_model.svh ====
`ifndef GLUE_MODEL_SVH
`define GLUE_MODEL_SVH

// reference state of the glue
logic       m_store80, m_ramrd, m_ramwrt, m_altzp;
logic       m_intcx, m_slotc3, m_80col, m_altch;
logic       m_page2, m_textg, m_mixg, m_hires;
logic       m_rdrom, m_lcram2, m_lcwe, m_lcpre;
logic [7:0] m_shadow, m_textcolor, m_newvideo, m_sltrom;
logic [7:0] m_vgcint, m_inten;
logic [3:0] m_border;
logic [4:3] m_intflag;

task automatic model_reset(input logic [7:0] sh, input logic [7:0] tc, input logic [7:0] nv);
	{m_store80, m_ramrd, m_ramwrt, m_altzp} = 4'b0;
	{m_intcx, m_slotc3, m_80col, m_altch} = 4'b0;
	{m_page2, m_textg, m_mixg, m_hires} = 4'b0;
	{m_lcram2, m_lcwe, m_lcpre} = 3'b0;
	m_rdrom = 1'b1;
	m_shadow = sh;
	m_textcolor = tc;
	m_newvideo = nv;
	m_sltrom = 8'h00;
	m_border = 4'h0;
	m_vgcint = 8'h00;
	m_inten = 8'h00;
	m_intflag = 2'b00;
endtask

function automatic logic model_is_io(input logic [7:0] bank, input logic [15:0] addr);
	logic bank_ok;
	bank_ok = (bank == 8'h00) || (bank == 8'h01) || (bank == 8'hE0) || (bank == 8'hE1);
	return bank_ok && (addr[15:8] == 8'hC0) && !m_shadow[6];
endfunction

function automatic logic [7:0] model_read(input logic [7:0] off, input logic vbl);
	case (off)
		8'h11: return {m_lcram2, 7'b0};
		8'h12: return {m_rdrom, 7'b0};
		8'h13: return {m_ramrd, 7'b0};
		8'h14: return {m_ramwrt, 7'b0};
		8'h15: return {m_intcx, 7'b0};
		8'h16: return {m_altzp, 7'b0};
		8'h17: return {m_slotc3, 7'b0};
		8'h18: return {m_store80, 7'b0};
		8'h19: return {~vbl, 7'b0};  // high outside blanking
		8'h1A: return {m_textg, 7'b0};
		8'h1B: return {m_mixg, 7'b0};
		8'h1C: return {m_page2, 7'b0};
		8'h1D: return {~m_hires, 7'b0};
		8'h1E: return {m_altch, 7'b0};
		8'h1F: return {m_80col, 7'b0};
		8'h22: return m_textcolor;
		8'h23: return m_vgcint;
		8'h29: return m_newvideo;
		8'h2D: return m_sltrom;
		8'h34: return {4'h0, m_border};
		8'h35: return m_shadow;
		8'h41: return m_inten;
		8'h68: return {m_altzp, m_page2, m_ramrd, m_ramwrt, m_rdrom, m_lcram2, 1'b0, m_intcx};
		default: return 8'h00;
	endcase
endfunction

// one strobed IO access, called only when the access hits the IO page
task automatic model_access(input logic we, input logic [7:0] off, input logic [7:0] data);
	logic v5, v6;
	if (off[7:4] == 4'h0) begin
		case (off[3:1])  // odd offset sets
			3'd0: if (we) m_store80 = off[0];
			3'd1: m_ramrd = off[0];
			3'd2: m_ramwrt = off[0];
			3'd3: if (we) m_intcx = off[0];
			3'd4: if (we) m_altzp = off[0];
			3'd5: if (we) m_slotc3 = off[0];
			3'd6: if (we) m_80col = off[0];
			default: if (we) m_altch = off[0];
		endcase
	end else if (off[7:3] == 5'b01010) begin
		case (off[2:1])
			2'd0: m_textg = off[0];
			2'd1: m_mixg = off[0];
			2'd2: m_page2 = off[0];
			default: m_hires = off[0];
		endcase
	end else if (off[7:4] == 4'h8) begin
		m_lcram2 = !off[3];
		m_rdrom = off[1] ^ off[0];
		if (!we && off[0]) begin
			m_lcwe = m_lcpre;  // needs two odd reads in a row
			m_lcpre = 1'b1;
		end else begin
			m_lcwe = 1'b0;
			m_lcpre = 1'b0;
		end
	end else if (we) begin
		case (off)
			8'h22: m_textcolor = data;
			8'h23: m_vgcint[2:1] = data[2:1];
			8'h29: m_newvideo = data;
			8'h2D: m_sltrom = data;
			8'h34: m_border = data[3:0];
			8'h35: m_shadow = data;
			8'h32: begin
				v6 = m_vgcint[6] & data[6];
				v5 = m_vgcint[5] & data[5];
				m_vgcint[6] = v6;
				m_vgcint[5] = v5;
				if (!(v5 || v6))
					m_vgcint[7] = 1'b0;
			end
			8'h41: m_inten[4:0] = data[4:0];
			8'h47: m_intflag = 2'b00;
			8'h68: begin
				{m_altzp, m_page2, m_ramrd, m_ramwrt, m_rdrom, m_lcram2} = data[7:2];
				m_intcx = data[0];
			end
			default: ;
		endcase
	end
endtask

// ev bits: scanline, one second, vbl, quarter second
task automatic model_events(input logic [3:0] ev);
	if (ev[0]) begin
		m_vgcint[5] = 1'b1;
		if (m_vgcint[1])
			m_vgcint[7] = 1'b1;
	end
	if (ev[1] && m_vgcint[2]) begin
		m_vgcint[6] = 1'b1;
		m_vgcint[7] = 1'b1;
	end
	if (ev[2] && m_inten[3])
		m_intflag[3] = 1'b1;
	if (ev[3] && m_inten[4])
		m_intflag[4] = 1'b1;
endtask

function automatic logic model_irq();
	return (m_vgcint[6] & m_vgcint[2]) | (m_vgcint[5] & m_vgcint[1]) |
		(m_intflag[3] & m_inten[3]) | (m_intflag[4] & m_inten[4]);
endfunction

// returns {bank, address} seen by memory
function automatic logic [23:0] model_map(input logic [7:0] bank, input logic [15:0] addr,
		input logic we);
	logic aux;
	logic [15:0] ma;
	aux = 1'b0;
	if (bank == 8'h00 || bank == 8'hE0) begin
		if (addr[15:8] <= 8'h01 || addr[15:8] >= 8'hC0)
			aux = m_altzp;
		else if (addr[15:8] >= 8'h04 && addr[15:8] <= 8'h07 && m_store80)
			aux = m_page2;
		else if (addr[15:8] >= 8'h20 && addr[15:8] <= 8'h3F && m_store80 && m_hires)
			aux = m_page2;
		else
			aux = we ? m_ramwrt : m_ramrd;
	end
	ma = addr;
	if (addr[15:12] == 4'hD && m_lcram2 && !m_rdrom && (bank >= 8'hE0 || !m_shadow[6]))
		ma = addr - 16'h1000;
	return {aux ? bank + 8'h01 : bank, ma};
endfunction

`endif

// ==== bench/tb_iigs_glue.sv ====
`timescale 1ns/10ps

module tb_iigs_glue import iigs_pkg::*; ();

	localparam byte_t SHADOW_INIT    = 8'h08;
	localparam byte_t TEXTCOLOR_INIT = 8'hF2;
	localparam byte_t NEWVIDEO_INIT  = 8'h41;
	localparam int    NUM_ACCESS     = 4000;  // IO space open
	localparam int    LOCKED_ACCESS  = 300;   // after shadow bit 6 is set
	localparam int    CYCLES_PER_ACCESS = 1;
	localparam int    CLK_PERIOD     = 8;

	logic       clk_sys, cpu_vda, bus_strobe, cpu_we, vblank;
	bank_t      cpu_bank, mem_bank;
	addr16_t    cpu_addr, mem_addr;
	byte_t      cpu_wdata, rd_data, shadow, textcolor, newvideo;
	logic       scanline_irq, vbl_irq, onesecond_irq, qtrsecond_irq;
	logic       rd_valid, irq, page2, textg, mixg, hires_mode, rdrom, lcram2, lc_we;
	logic [3:0] bordercolor;

	integer seed = 32'h3fd3;
	int     errors = 0;
	int     checks = 0;
	byte_t  rd_hold;          // last value read back
	logic   rd_seen = 1'b0;

	`include "glue_model.svh"

	iigs_glue #(
		.SHADOW_INIT   (SHADOW_INIT),
		.TEXTCOLOR_INIT(TEXTCOLOR_INIT),
		.NEWVIDEO_INIT (NEWVIDEO_INIT)
	) dut_i (.*);

	initial begin
		clk_sys = 1'b0;
		forever #(CLK_PERIOD / 2) clk_sys = ~clk_sys;
	end

	task automatic compare_value(input string name, input logic [23:0] got,
			input logic [23:0] exp);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("Mismatch %s got %h expected %h at %0t", name, got, exp, $time);
		end
	endtask

	// one clock of stimulus, entered 1 ns after a rising edge
	task automatic run_cycle(input logic strobe, input logic we, input bank_t bank,
			input addr16_t addr, input byte_t data, input logic [3:0] ev, input logic vbl);
		logic        io, io_rd;
		byte_t       rd_exp;
		logic [23:0] map_exp;
		bus_strobe = strobe;
		cpu_we = we;
		cpu_bank = bank;
		cpu_addr = addr;
		cpu_wdata = data;
		vblank = vbl;
		{qtrsecond_irq, vbl_irq, onesecond_irq, scanline_irq} = ev;
		#1;
		map_exp = model_map(bank, addr, we);  // zero latency mapping
		compare_value("mem_bank", mem_bank, map_exp[23:16]);
		compare_value("mem_addr", mem_addr, map_exp[15:0]);
		io = strobe && model_is_io(bank, addr);
		io_rd = io && !we;
		rd_exp = model_read(addr[7:0], vbl);
		@(posedge clk_sys);
		if (io)
			model_access(we, addr[7:0], data);
		model_events(ev);
		#1;
		compare_value("rd_valid", rd_valid, io_rd);
		if (io_rd) begin
			rd_hold = rd_exp;
			rd_seen = 1'b1;
		end
		if (rd_seen)
			compare_value("rd_data", rd_data, rd_hold);  // also holds between reads
		compare_value("irq", irq, model_irq());
		compare_value("shadow", shadow, m_shadow);
		compare_value("textcolor", textcolor, m_textcolor);
		compare_value("bordercolor", bordercolor, m_border);
		compare_value("newvideo", newvideo, m_newvideo);
		compare_value("page2", page2, m_page2);
		compare_value("textg", textg, m_textg);
		compare_value("mixg", mixg, m_mixg);
		compare_value("hires_mode", hires_mode, m_hires);
		compare_value("rdrom", rdrom, m_rdrom);
		compare_value("lcram2", lcram2, m_lcram2);
		compare_value("lc_we", lc_we, m_lcwe);
	endtask

	function automatic byte_t reg_offset(input logic [3:0] idx);
		case (idx)
			4'd0: return 8'h22;
			4'd1: return 8'h23;
			4'd2: return 8'h29;
			4'd3: return 8'h2D;
			4'd4, 4'd10: return 8'h32;
			4'd5: return 8'h34;
			4'd6: return 8'h35;
			4'd7, 4'd11: return 8'h41;
			4'd8, 4'd12: return 8'h47;
			default: return 8'h68;
		endcase
	endfunction

	task automatic random_cycle(input logic locked);
		int         r;
		logic       strobe;
		bank_t      bank;
		addr16_t    addr;
		byte_t      data, off;
		logic [3:0] ev;
		r = $random(seed);
		data = $random(seed);
		addr = $random(seed);
		strobe = r[1:0] != 2'b00;
		case (r[4:3])
			2'd0: bank = BANK_MAIN;
			2'd1: bank = BANK_AUX;
			2'd2: bank = BANK_MEGA_MAIN;
			default: bank = BANK_MEGA_AUX;
		endcase
		case (r[7:5])  // bias toward switch pairs, LC and registers
			3'd0: off = {4'h0, r[11:8]};
			3'd1: off = {5'b01010, r[10:8]};
			3'd2: off = {4'h8, r[11:8]};
			3'd3, 3'd4: off = reg_offset(r[11:8]);
			3'd5: off = {4'h1, r[11:8]};
			default: off = addr[7:0];
		endcase
		if (r[7:5] != 3'd7 || r[21])
			addr = {IO_PAGE, off};
		if (!locked && addr == 16'hC035)
			data[6] = 1'b0;  // keep IO page open
		ev = strobe ? 4'h0 : r[15:12] & r[19:16];
		run_cycle(strobe, r[2], bank, addr, data, ev, r[20]);
	endtask

	initial begin
		{bus_strobe, cpu_we, vblank} = 3'b0;
		{scanline_irq, vbl_irq, onesecond_irq, qtrsecond_irq} = 4'b0;
		cpu_bank = 8'h00;
		cpu_addr = 16'h0000;
		cpu_wdata = 8'h00;
		cpu_vda = 1'b1;
		model_reset(SHADOW_INIT, TEXTCOLOR_INIT, NEWVIDEO_INIT);
		repeat (16) @(posedge clk_sys);
		#1 cpu_vda = 1'b0;
		run_cycle(1'b0, 1'b0, BANK_MAIN, 16'h0000, 8'h00, 4'h0, 1'b0);  // idle, reset values
		for (int i = 0; i < NUM_ACCESS; i++)
			random_cycle(1'b0);
		run_cycle(1'b1, 1'b1, BANK_MAIN, 16'hC035, 8'h48, 4'h0, 1'b0);  // IO off
		for (int i = 0; i < LOCKED_ACCESS; i++)
			random_cycle(1'b1);
		$display("checks %0d errors %0d", checks, errors);
		if (errors == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

	initial begin
		#((16 + (NUM_ACCESS + LOCKED_ACCESS + 2) * CYCLES_PER_ACCESS + 200) * CLK_PERIOD);
		$display("watchdog expired before the test sequence finished");
		$display("TB FAILED");
		$finish;
	end

endmodule

// ==== sim.f ====
+incdir+bench
source/iigs_pkg.sv
source/softswitch_regs.sv
source/lang_card.sv
source/aux_map.sv
source/irq_ctrl.sv
source/iigs_glue.sv
bench/tb_iigs_glue.sv

// ==== Bender.yml ====
package:
  name: iigs_glue

sources:
  - files:
      - source/iigs_pkg.sv
      - source/softswitch_regs.sv
      - source/lang_card.sv
      - source/aux_map.sv
      - source/irq_ctrl.sv
      - source/iigs_glue.sv
  - target: test
    include_dirs:
      - bench
    files:
      - bench/tb_iigs_glue.sv
